/* Bender.yml */
package:
  name: rv_core

sources:
  - include_dirs:
      - include
    files:
      - design/rv_pkg.sv
      - design/rv_if.sv
      - design/rv_fetch.sv
      - design/rv_decode.sv
      - design/rv_execute.sv
      - design/rv_memory.sv
      - design/rv_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/rv_core_tb.sv

/* compile.f */
+incdir+include
design/rv_pkg.sv
design/rv_if.sv
design/rv_fetch.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_memory.sv
design/rv_core.sv
dv/rv_core_tb.sv

/* design/rv_core.sv */
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_core (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`RV_XLEN-1:0]   imem_rdata,
  input  logic [`RV_XLEN-1:0]   mem_rdata,
  output logic [`RV_XLEN-1:0]   imem_addr,
  output logic [`RV_XLEN-1:0]   mem_addr,
  output logic [`RV_XLEN-1:0]   mem_wdata,
  output logic [`RV_STRB_W-1:0] mem_wstrb,
  output logic                  mem_rstrb
);
  import rv_pkg::*;

  if_id_t  if_id;
  id_ex_t  id_ex;
  ex_mem_t ex_mem;

  rv_bypass_if   bypass_if ();
  rv_redirect_if redirect_if ();   // Driven by memory stage

  rv_fetch fetch_i (
    .clk        (clk),
    .rst        (rst),
    .redirect   (redirect_if.sink),
    .imem_rdata (imem_rdata),
    .imem_addr  (imem_addr),
    .if_id      (if_id)
  );

  rv_decode decode_i (
    .clk      (clk),
    .rst      (rst),
    .if_id    (if_id),
    .bypass   (bypass_if.consumer),  // Writeback port of the register file
    .redirect (redirect_if.sink),
    .id_ex    (id_ex)
  );

  rv_execute execute_i (
    .clk      (clk),
    .rst      (rst),
    .id_ex    (id_ex),
    .bypass   (bypass_if.consumer),
    .redirect (redirect_if.sink),
    .ex_mem   (ex_mem)
  );

  rv_memory memory_i (
    .clk       (clk),
    .rst       (rst),
    .ex_mem    (ex_mem),
    .mem_rdata (mem_rdata),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .mem_rstrb (mem_rstrb),
    .redirect  (redirect_if.source),
    .bypass    (bypass_if.producer)
  );

endmodule

/* design/rv_decode.sv */
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_decode (
  input  logic           clk,
  input  logic           rst,
  input  rv_pkg::if_id_t if_id,
  rv_bypass_if.consumer  bypass,
  rv_redirect_if.sink    redirect,
  output rv_pkg::id_ex_t id_ex
);
  import rv_pkg::*;

  logic [`RV_XLEN-1:0]   regs [1:31];  // x0 is not stored
  logic [`RV_XLEN-1:0]   instr;
  logic [`RV_REG_AW-1:0] rs1, rs2, rd;
  logic [2:0]            funct3;
  logic [`RV_XLEN-1:0]   rs1_val, rs2_val;
  logic [`RV_XLEN-1:0]   imm_i, imm_s, imm_b, imm_j, imm_u;
  id_ex_t                ctl;          // Decoded fields, pc and values filled below
  logic                  known;
  logic                  reads_rs1;
  logic                  reads_rs2;

  assign instr  = if_id.instr;
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign rd     = instr[11:7];
  assign funct3 = instr[14:12];

  always_ff @(posedge clk) begin
    if (reg_hit(bypass.wb_we, bypass.wb_rd, bypass.wb_rd)) begin
      regs[bypass.wb_rd] <= bypass.wb_value;
    end
  end

  // Write-first, a same-cycle writeback is seen by decode
  assign rs1_val = (rs1 == '0) ? '0 :
                   reg_hit(bypass.wb_we, bypass.wb_rd, rs1) ? bypass.wb_value : regs[rs1];
  assign rs2_val = (rs2 == '0) ? '0 :
                   reg_hit(bypass.wb_we, bypass.wb_rd, rs2) ? bypass.wb_value : regs[rs2];

  assign imm_i = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
  assign imm_s = {{(`RV_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{(`RV_XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                  instr[11:8], 1'b0};
  assign imm_j = {{(`RV_XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20],
                  instr[30:21], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};

  always_comb begin
    ctl         = '0;
    ctl.alu_op  = ALU_ADD;  // Address and link arithmetic
    ctl.imm     = imm_i;
    known       = (instr[1:0] == 2'b11);
    case (opcode_e'(instr[6:2]))
      OPC_OP: begin
        ctl.reg_write = 1'b1;
        case (funct3)
          3'b000:  ctl.alu_op = instr[30] ? ALU_SUB : ALU_ADD;
          3'b001:  ctl.alu_op = ALU_SLL;
          3'b010:  ctl.alu_op = ALU_SLT;
          3'b011:  ctl.alu_op = ALU_SLTU;
          3'b100:  ctl.alu_op = ALU_XOR;
          3'b101:  ctl.alu_op = instr[30] ? ALU_SRA : ALU_SRL;
          3'b110:  ctl.alu_op = ALU_OR;
          default: ctl.alu_op = ALU_AND;
        endcase
      end
      OPC_OP_IMM: begin
        ctl.reg_write = 1'b1;
        ctl.use_imm   = 1'b1;
        case (funct3)
          3'b000:  ctl.alu_op = ALU_ADD;  // No SUBI, bit 30 is immediate
          3'b001:  ctl.alu_op = ALU_SLL;
          3'b010:  ctl.alu_op = ALU_SLT;
          3'b011:  ctl.alu_op = ALU_SLTU;
          3'b100:  ctl.alu_op = ALU_XOR;
          3'b101:  ctl.alu_op = instr[30] ? ALU_SRA : ALU_SRL;
          3'b110:  ctl.alu_op = ALU_OR;
          default: ctl.alu_op = ALU_AND;
        endcase
      end
      OPC_LOAD: begin
        ctl.load      = 1'b1;
        ctl.reg_write = 1'b1;
        ctl.use_imm   = 1'b1;
      end
      OPC_STORE: begin
        ctl.store   = 1'b1;
        ctl.use_imm = 1'b1;
        ctl.imm     = imm_s;
      end
      OPC_LUI: begin
        ctl.reg_write = 1'b1;
        ctl.use_imm   = 1'b1;
        ctl.zero_a    = 1'b1;  // 0 + imm_u
        ctl.imm       = imm_u;
      end
      OPC_BRANCH: begin
        ctl.branch = 1'b1;   // Compare flags come from rs1 vs rs2
        ctl.imm    = imm_b;
      end
      OPC_JAL: begin
        ctl.jal       = 1'b1;
        ctl.reg_write = 1'b1;
        ctl.imm       = imm_j;
      end
      default: known = 1'b0;
    endcase
  end

  // Register operands the decoded instruction really consumes
  assign reads_rs1 = !ctl.zero_a && !ctl.jal;
  assign reads_rs2 = (!ctl.use_imm && !ctl.jal) || ctl.store;  // Store data is rs2

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      id_ex.valid <= 1'b0;
    end else begin
      id_ex         <= ctl;
      id_ex.valid   <= if_id.valid && known && !redirect.taken;
      id_ex.pc      <= if_id.pc;
      id_ex.rs1_val <= rs1_val;
      id_ex.rs2_val <= rs2_val;
      id_ex.rs1     <= rs1;
      id_ex.rs2     <= rs2;
      id_ex.rd      <= rd;
      id_ex.funct3  <= funct3;
    end
  end

  // No load-use stall, so the next instruction must not read the loaded register
  load_use_free: assert property (
    @(posedge clk) disable iff (rst)
    (id_ex.valid && id_ex.load && id_ex.rd != '0 &&
     if_id.valid && known && !redirect.taken) |->
    !((reads_rs1 && rs1 == id_ex.rd) || (reads_rs2 && rs2 == id_ex.rd))
  );

endmodule

/* design/rv_execute.sv */
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_execute (
  input  logic            clk,
  input  logic            rst,
  input  rv_pkg::id_ex_t  id_ex,
  rv_bypass_if.consumer   bypass,
  rv_redirect_if.sink     redirect,
  output rv_pkg::ex_mem_t ex_mem
);
  import rv_pkg::*;

  logic [`RV_XLEN-1:0] rs1_fwd;
  logic [`RV_XLEN-1:0] rs2_fwd;    // Also the store data
  logic [`RV_XLEN-1:0] op_a;
  logic [`RV_XLEN-1:0] op_b;
  logic [`RV_XLEN-1:0] alu_res;
  logic [4:0]          shamt;
  logic                zero, lt, ltu;

  // Memory stage is younger, so it wins over writeback
  assign rs1_fwd = reg_hit(bypass.mem_we, bypass.mem_rd, id_ex.rs1) ? bypass.mem_value :
                   reg_hit(bypass.wb_we, bypass.wb_rd, id_ex.rs1)   ? bypass.wb_value  :
                   id_ex.rs1_val;
  assign rs2_fwd = reg_hit(bypass.mem_we, bypass.mem_rd, id_ex.rs2) ? bypass.mem_value :
                   reg_hit(bypass.wb_we, bypass.wb_rd, id_ex.rs2)   ? bypass.wb_value  :
                   id_ex.rs2_val;

  assign op_a  = id_ex.zero_a ? '0 : rs1_fwd;
  assign op_b  = id_ex.use_imm ? id_ex.imm : rs2_fwd;
  assign shamt = op_b[4:0];

  // Flags serve SLT/SLTU here and branch resolution one stage later
  assign zero = (op_a == op_b);
  assign lt   = $signed(op_a) < $signed(op_b);
  assign ltu  = op_a < op_b;

  always_comb begin
    case (id_ex.alu_op)
      ALU_ADD:  alu_res = op_a + op_b;
      ALU_SUB:  alu_res = op_a - op_b;
      ALU_AND:  alu_res = op_a & op_b;
      ALU_OR:   alu_res = op_a | op_b;
      ALU_XOR:  alu_res = op_a ^ op_b;
      ALU_SLL:  alu_res = op_a << shamt;
      ALU_SRL:  alu_res = op_a >> shamt;
      ALU_SRA:  alu_res = $signed(op_a) >>> shamt;
      ALU_SLT:  alu_res = {{(`RV_XLEN-1){1'b0}}, lt};
      ALU_SLTU: alu_res = {{(`RV_XLEN-1){1'b0}}, ltu};
      default:  alu_res = '0;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ex_mem.valid <= 1'b0;
    end else begin
      ex_mem.valid      <= id_ex.valid && !redirect.taken;  // Younger than the redirect
      ex_mem.result     <= alu_res;
      ex_mem.store_data <= rs2_fwd;
      ex_mem.target     <= id_ex.pc + id_ex.imm;   // B or J immediate
      ex_mem.pc4        <= id_ex.pc + `RV_XLEN'(4);
      ex_mem.rd         <= id_ex.rd;
      ex_mem.funct3     <= id_ex.funct3;
      ex_mem.zero       <= zero;
      ex_mem.lt         <= lt;
      ex_mem.ltu        <= ltu;
      ex_mem.load       <= id_ex.load;
      ex_mem.store      <= id_ex.store;
      ex_mem.reg_write  <= id_ex.reg_write;
      ex_mem.branch     <= id_ex.branch;
      ex_mem.jal        <= id_ex.jal;
    end
  end

endmodule

/* design/rv_fetch.sv */
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_fetch (
  input  logic                clk,
  input  logic                rst,
  rv_redirect_if.sink         redirect,
  input  logic [`RV_XLEN-1:0] imem_rdata,
  output logic [`RV_XLEN-1:0] imem_addr,
  output rv_pkg::if_id_t      if_id
);

  logic [`RV_XLEN-1:0] pc_q;
  logic [`RV_XLEN-1:0] pc_next;

  assign imem_addr = pc_q;  // Combinational fetch, word back this cycle

  // Redirect wins over sequential flow
  assign pc_next = redirect.taken ? redirect.target : pc_q + `RV_XLEN'(4);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc_q <= `RV_RESET_PC;
    end else begin
      pc_q <= pc_next;
    end
  end

  // Fetch/decode register, only valid carries reset
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      if_id.valid <= 1'b0;
    end else begin
      if_id.valid <= !redirect.taken;  // Word fetched on the wrong path
      if_id.instr <= redirect.taken ? `RV_NOP : imem_rdata;
      if_id.pc    <= pc_q;
    end
  end

  // Targets come from execute, so a bad immediate would show up here
  pc_word_aligned: assert property (
    @(posedge clk) disable iff (rst) pc_q[1:0] == 2'b00
  );

endmodule

/* design/rv_if.sv */
`timescale 1ns/1ps
`include "rv_settings.svh"

// Result forwarding from the memory and writeback stages
interface rv_bypass_if;
  logic [`RV_REG_AW-1:0] mem_rd;
  logic                  mem_we;     // Low for loads, data not ready yet
  logic [`RV_XLEN-1:0]   mem_value;
  logic [`RV_REG_AW-1:0] wb_rd;
  logic                  wb_we;
  logic [`RV_XLEN-1:0]   wb_value;  // Also the register file write port

  modport producer (
    output mem_rd, mem_we, mem_value,
    output wb_rd, wb_we, wb_value
  );
  modport consumer (
    input mem_rd, mem_we, mem_value,
    input wb_rd, wb_we, wb_value
  );
endinterface

// Taken branch or JAL from the memory stage
interface rv_redirect_if;
  logic                taken;   // Single cycle, doubles as flush
  logic [`RV_XLEN-1:0] target;

  modport source (output taken, target);
  modport sink (input taken, target);
endinterface

/* design/rv_memory.sv */
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_memory (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_pkg::ex_mem_t       ex_mem,
  input  logic [`RV_XLEN-1:0]   mem_rdata,
  output logic [`RV_XLEN-1:0]   mem_addr,
  output logic [`RV_XLEN-1:0]   mem_wdata,
  output logic [`RV_STRB_W-1:0] mem_wstrb,
  output logic                  mem_rstrb,
  rv_redirect_if.source         redirect,
  rv_bypass_if.producer         bypass
);
  import rv_pkg::*;

  logic                  cond;
  logic [`RV_STRB_W-1:0] strb;
  logic [15:0]           half;
  logic [7:0]            byte_sel;
  logic                  sext;
  logic [`RV_XLEN-1:0]   load_val;
  logic [`RV_XLEN-1:0]   wb_value;
  mem_wb_t               mem_wb_q;

  always_comb begin
    case (ex_mem.funct3)
      3'b000:  cond = ex_mem.zero;   // BEQ
      3'b001:  cond = !ex_mem.zero;  // BNE
      3'b100:  cond = ex_mem.lt;
      3'b101:  cond = !ex_mem.lt;
      3'b110:  cond = ex_mem.ltu;
      3'b111:  cond = !ex_mem.ltu;
      default: cond = 1'b0;
    endcase
  end

  assign redirect.taken  = ex_mem.valid && (ex_mem.jal || (ex_mem.branch && cond));
  assign redirect.target = ex_mem.target;

  assign mem_addr  = ex_mem.result;
  assign mem_wdata = (ex_mem.funct3[1:0] == 2'b10) ? ex_mem.store_data :
                     (ex_mem.funct3[1:0] == 2'b01) ? {2{ex_mem.store_data[15:0]}} :
                     {4{ex_mem.store_data[7:0]}};  // Same byte on every lane

  always_comb begin
    case (ex_mem.funct3[1:0])
      2'b00:   strb = `RV_STRB_W'(1) << mem_addr[1:0];
      2'b01:   strb = mem_addr[1] ? 4'b1100 : 4'b0011;
      2'b10:   strb = '1;
      default: strb = '0;
    endcase
  end

  assign mem_wstrb = (ex_mem.valid && ex_mem.store) ? strb : '0;
  assign mem_rstrb = ex_mem.valid && ex_mem.load;

  // Lane select then extend, funct3[2] marks LBU and LHU
  assign half     = mem_addr[1] ? mem_rdata[31:16] : mem_rdata[15:0];
  assign byte_sel = mem_addr[0] ? half[15:8] : half[7:0];
  assign sext     = !ex_mem.funct3[2];
  assign load_val = (ex_mem.funct3[1:0] == 2'b00) ? {{24{sext & byte_sel[7]}}, byte_sel} :
                    (ex_mem.funct3[1:0] == 2'b01) ? {{16{sext & half[15]}}, half} :
                    mem_rdata;

  assign wb_value = ex_mem.jal  ? ex_mem.pc4 :
                    ex_mem.load ? load_val : ex_mem.result;

  // Load data is too late for execute this cycle
  assign bypass.mem_rd    = ex_mem.rd;
  assign bypass.mem_we    = ex_mem.valid && ex_mem.reg_write && !ex_mem.load;
  assign bypass.mem_value = wb_value;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      mem_wb_q.valid <= 1'b0;
    end else begin
      mem_wb_q.valid     <= ex_mem.valid;  // Redirecting instruction still retires
      mem_wb_q.rd        <= ex_mem.rd;
      mem_wb_q.reg_write <= ex_mem.reg_write;
      mem_wb_q.value     <= wb_value;
    end
  end

  assign bypass.wb_rd    = mem_wb_q.rd;
  assign bypass.wb_we    = mem_wb_q.valid && mem_wb_q.reg_write;
  assign bypass.wb_value = mem_wb_q.value;

  // Flushed slot from execute must never reach the bus
  store_only_when_valid: assert property (
    @(posedge clk) disable iff (rst)
    (mem_wstrb != '0) |-> (ex_mem.valid && ex_mem.store && !$past(redirect.taken))
  );

endmodule

/* design/rv_pkg.sv */
`include "rv_settings.svh"

package rv_pkg;

  // Major opcode, instr[6:2]
  typedef enum logic [4:0] {
    OPC_LOAD   = 5'b00000,
    OPC_OP_IMM = 5'b00100,
    OPC_STORE  = 5'b01000,
    OPC_OP     = 5'b01100,
    OPC_LUI    = 5'b01101,
    OPC_BRANCH = 5'b11000,
    OPC_JAL    = 5'b11011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
  } alu_op_e;

  typedef struct packed {
    logic                valid;
    logic [`RV_XLEN-1:0] instr;
    logic [`RV_XLEN-1:0] pc;
  } if_id_t;

  typedef struct packed {
    logic                  valid;
    logic [`RV_XLEN-1:0]   pc;
    logic [`RV_XLEN-1:0]   rs1_val;
    logic [`RV_XLEN-1:0]   rs2_val;
    logic [`RV_XLEN-1:0]   imm;
    logic [`RV_REG_AW-1:0] rs1;
    logic [`RV_REG_AW-1:0] rs2;
    logic [`RV_REG_AW-1:0] rd;
    alu_op_e               alu_op;
    logic                  use_imm;   // Operand b from immediate
    logic                  zero_a;    // Operand a forced to zero, LUI
    logic                  load;
    logic                  store;
    logic                  reg_write;
    logic                  branch;
    logic                  jal;
    logic [2:0]            funct3;
  } id_ex_t;

  typedef struct packed {
    logic                  valid;
    logic [`RV_XLEN-1:0]   result;      // ALU result, also data address
    logic [`RV_XLEN-1:0]   store_data;
    logic [`RV_XLEN-1:0]   target;      // Branch or JAL destination
    logic [`RV_XLEN-1:0]   pc4;         // JAL link value
    logic [`RV_REG_AW-1:0] rd;
    logic [2:0]            funct3;
    logic                  zero;
    logic                  lt;
    logic                  ltu;
    logic                  load;
    logic                  store;
    logic                  reg_write;
    logic                  branch;
    logic                  jal;
  } ex_mem_t;

  typedef struct packed {
    logic                  valid;
    logic [`RV_REG_AW-1:0] rd;
    logic                  reg_write;
    logic [`RV_XLEN-1:0]   value;
  } mem_wb_t;

  // True when a writer targets idx, x0 excluded
  function automatic logic reg_hit(input logic we, input logic [`RV_REG_AW-1:0] rd,
                                   input logic [`RV_REG_AW-1:0] idx);
    return we && (rd != '0) && (rd == idx);
  endfunction

endpackage

/* dv/rv_core_tb.sv */
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_core_tb;

  localparam int PERIOD    = 40;
  localparam int RST_CYC   = 16;
  localparam int WAIT_MAX  = 200;  // Cycles allowed between two stores
  localparam int TAIL_CYC  = 20;
  localparam int LOADS     = 6;    // LB, LBU, LH, LHU, LW and LB in the program

  logic        clk;
  logic        rst;
  logic [31:0] imem_rdata;
  logic [31:0] mem_rdata;
  logic [31:0] imem_addr;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic [3:0]  mem_wstrb;
  logic        mem_rstrb;

  logic [31:0] imem [0:127];
  logic [31:0] dmem [0:255];
  logic [67:0] exp_q [$];  // {addr, data, strb}
  int          n_instr;
  int          n_reads;
  int          errors;
  int          checks;

  rv_core rv_core_i (
    .clk        (clk),
    .rst        (rst),
    .imem_rdata (imem_rdata),
    .mem_rdata  (mem_rdata),
    .imem_addr  (imem_addr),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_wstrb  (mem_wstrb),
    .mem_rstrb  (mem_rstrb)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Instruction memory, NOP past the program
  always_comb begin
    imem_rdata = (imem_addr < 32'd512) ? imem[imem_addr[8:2]] : `RV_NOP;
  end

  assign mem_rdata = dmem[mem_addr[9:2]];  // Combinational read

  always @(posedge clk) begin
    for (int b = 0; b < 4; b++) begin
      if (mem_wstrb[b]) dmem[mem_addr[9:2]][8*b +: 8] <= mem_wdata[8*b +: 8];
    end
  end

  // Cycles with a read strobe, one per load
  always @(negedge clk) begin
    if (!rst && mem_rstrb === 1'b1) n_reads++;
  end

  // RV32I encoders for building the program
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jal_op(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  task automatic emit(input logic [31:0] word);
    imem[n_instr] = word;
    n_instr++;
  endtask

  task automatic expect_store(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
    exp_q.push_back({addr, data, strb});
  endtask

  // Not-taken branch, marker store, taken branch over three poison stores
  task automatic branch_pair(input logic [2:0] f3, input logic [4:0] n1, input logic [4:0] n2,
                             input logic [4:0] t1, input logic [4:0] t2, input int k);
    emit(b_type(13'd8, n2, n1, f3));               // Falls through
    emit(s_type(12'h50 + 12'(4 * k), 5'd4, 5'd1, 3'b010));
    emit(b_type(13'd16, t2, t1, f3));
    repeat (3) emit(s_type(12'h7C, 5'd0, 5'd1, 3'b010));
    expect_store(32'h250 + 32'(4 * k), 32'd5, 4'hF);
  endtask

  task automatic build_program();
    n_instr = 0;
    for (int i = 0; i < 128; i++) imem[i] = `RV_NOP;
    for (int i = 0; i < 256; i++) dmem[i] = 32'hD000_0000 | (i << 2);
    dmem[8'h40] = 32'h8001_F07E;                       // Load source at 0x100
    emit(i_type(12'h200, 5'd0, 3'b000, 5'd1, 7'b0010011));  // x1 = base
    emit({20'h12345, 5'd2, 7'b0110111});                  // LUI x2
    emit(i_type(12'h678, 5'd2, 3'b000, 5'd3, 7'b0010011));  // Memory-stage bypass
    emit(s_type(12'h000, 5'd3, 5'd1, 3'b010));              // x1 via write-first
    emit(i_type(12'd5, 5'd0, 3'b000, 5'd4, 7'b0010011));
    emit(i_type(12'hFFD, 5'd0, 3'b000, 5'd5, 7'b0010011));  // x5 = -3
    emit(`RV_NOP);
    emit(r_type(7'h20, 5'd5, 5'd4, 3'b000, 5'd6));          // SUB, x5 via writeback
    emit(s_type(12'h004, 5'd6, 5'd1, 3'b010));
    emit(r_type(7'h00, 5'd4, 5'd5, 3'b010, 5'd7));          // SLT
    emit(r_type(7'h00, 5'd4, 5'd5, 3'b011, 5'd8));          // SLTU
    emit(r_type(7'h00, 5'd5, 5'd4, 3'b100, 5'd9));          // XOR
    emit(r_type(7'h20, 5'd4, 5'd5, 3'b101, 5'd10));         // SRA
    emit(r_type(7'h00, 5'd4, 5'd5, 3'b101, 5'd11));         // SRL
    emit(r_type(7'h00, 5'd4, 5'd4, 3'b001, 5'd12));         // SLL
    emit(r_type(7'h00, 5'd12, 5'd7, 3'b110, 5'd13));        // OR
    emit(r_type(7'h00, 5'd11, 5'd9, 3'b111, 5'd14));        // AND
    emit(s_type(12'h008, 5'd13, 5'd1, 3'b010));
    emit(s_type(12'h00C, 5'd14, 5'd1, 3'b010));
    emit(s_type(12'h010, 5'd10, 5'd1, 3'b010));
    emit(s_type(12'h014, 5'd8, 5'd1, 3'b010));
    for (int o = 0; o < 4; o++) emit(s_type(12'h020 + 12'(o), 5'd3, 5'd1, 3'b000));  // SB
    emit(s_type(12'h024, 5'd3, 5'd1, 3'b001));              // SH low half
    emit(s_type(12'h026, 5'd3, 5'd1, 3'b001));              // SH high half
    emit(i_type(12'h100, 5'd0, 3'b000, 5'd16, 7'b0010011));
    emit(i_type(12'd1, 5'd16, 3'b000, 5'd17, 7'b0000011));  // LB
    emit(i_type(12'd1, 5'd16, 3'b100, 5'd18, 7'b0000011));  // LBU
    emit(s_type(12'h030, 5'd17, 5'd1, 3'b010));
    emit(s_type(12'h034, 5'd18, 5'd1, 3'b010));
    emit(i_type(12'd2, 5'd16, 3'b001, 5'd19, 7'b0000011));  // LH
    emit(i_type(12'd0, 5'd16, 3'b101, 5'd20, 7'b0000011));  // LHU
    emit(s_type(12'h038, 5'd19, 5'd1, 3'b010));
    emit(s_type(12'h03C, 5'd20, 5'd1, 3'b010));
    emit(i_type(12'd0, 5'd16, 3'b010, 5'd21, 7'b0000011));  // LW
    emit(i_type(12'd0, 5'd16, 3'b000, 5'd22, 7'b0000011));  // LB of lane 0
    emit(s_type(12'h040, 5'd21, 5'd1, 3'b010));
    emit(s_type(12'h044, 5'd22, 5'd1, 3'b010));

    expect_store(32'h200, 32'h1234_5678, 4'hF);
    expect_store(32'h204, 32'h0000_0008, 4'hF);
    expect_store(32'h208, 32'h0000_00A1, 4'hF);
    expect_store(32'h20C, 32'h07FF_FFF8, 4'hF);
    expect_store(32'h210, 32'hFFFF_FFFF, 4'hF);
    expect_store(32'h214, 32'h0000_0000, 4'hF);
    expect_store(32'h220, 32'h7878_7878, 4'h1);
    expect_store(32'h221, 32'h7878_7878, 4'h2);
    expect_store(32'h222, 32'h7878_7878, 4'h4);
    expect_store(32'h223, 32'h7878_7878, 4'h8);
    expect_store(32'h224, 32'h5678_5678, 4'h3);
    expect_store(32'h226, 32'h5678_5678, 4'hC);
    expect_store(32'h230, 32'hFFFF_FFF0, 4'hF);
    expect_store(32'h234, 32'h0000_00F0, 4'hF);
    expect_store(32'h238, 32'hFFFF_8001, 4'hF);
    expect_store(32'h23C, 32'h0000_F07E, 4'hF);
    expect_store(32'h240, 32'h8001_F07E, 4'hF);
    expect_store(32'h244, 32'h0000_007E, 4'hF);

    // x4 = 5, x5 = -3
    branch_pair(3'b000, 5'd4, 5'd5, 5'd4, 5'd4, 0);  // BEQ
    branch_pair(3'b001, 5'd4, 5'd4, 5'd4, 5'd5, 1);  // BNE
    branch_pair(3'b100, 5'd4, 5'd5, 5'd5, 5'd4, 2);  // BLT
    branch_pair(3'b101, 5'd5, 5'd4, 5'd4, 5'd5, 3);  // BGE
    branch_pair(3'b110, 5'd5, 5'd4, 5'd4, 5'd5, 4);  // BLTU
    branch_pair(3'b111, 5'd4, 5'd5, 5'd5, 5'd4, 5);  // BGEU

    emit(jal_op(21'd16, 5'd23));                      // At 0x130, link 0x134
    repeat (3) emit(s_type(12'h07C, 5'd0, 5'd1, 3'b010));
    emit(s_type(12'h070, 5'd23, 5'd1, 3'b010));
    expect_store(32'h270, 32'h0000_0134, 4'hF);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR @%0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // Next cycle with a write strobe, sampled at the falling edge
  task automatic wait_for_store(output bit found);
    found = 1'b0;
    for (int c = 0; c < WAIT_MAX && !found; c++) begin
      @(negedge clk);
      if (mem_wstrb !== 4'h0) found = 1'b1;
    end
  endtask

  initial begin
    bit          found;
    bit          timed_out;
    logic [67:0] e;
    errors    = 0;
    checks    = 0;
    n_reads   = 0;
    timed_out = 1'b0;
    rst       = 1'b1;
    build_program();
    repeat (RST_CYC) @(posedge clk);
    #2 rst = 1'b0;
    @(negedge clk);
    check_value("imem_addr", imem_addr, `RV_RESET_PC);
    check_value("mem_wstrb", {28'h0, mem_wstrb}, 32'h0);
    check_value("mem_rstrb", {31'h0, mem_rstrb}, 32'h0);

    foreach (exp_q[i]) begin
      e = exp_q[i];
      wait_for_store(found);
      if (!found) begin
        $display("Timed out waiting for store %0d at address %h", i, e[67:36]);
        timed_out = 1'b1;
        break;
      end
      check_value("mem_addr", mem_addr, e[67:36]);
      check_value("mem_wdata", mem_wdata, e[35:4]);
      check_value("mem_wstrb", {28'h0, mem_wstrb}, {28'h0, e[3:0]});
    end

    // Poison stores after taken branches must never show up
    if (!timed_out) begin
      repeat (TAIL_CYC) begin
        @(negedge clk);
        if (mem_wstrb !== 4'h0) begin
          errors++;
          $display("Unexpected extra store to address %h after the last expected one",
                   mem_addr);
        end
      end
      check_value("mem_rstrb cycles", n_reads, LOADS);
    end

    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timed_out);
    if (errors == 0 && !timed_out) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* include/rv_settings.svh */
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// Data path and address width
`define RV_XLEN 32

// Register index width, 32 architectural registers
`define RV_REG_AW 5

// One enable per byte lane of a data word
`define RV_STRB_W 4

// ADDI x0, x0, 0
`define RV_NOP 32'h0000_0013

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif
